// File: edge_sync.sv
// ******************************
// Input synchronizer and rising edge strobe
// ******************************

`timescale 1ns/1ps

module edge_sync (
  input  logic ref_clk,
  input  logic reset,
  input  logic square_signal,
  output logic edge_strobe
);

  // ******************************
  // Synchronizer chain
  // ******************************

  // Bit 0 samples the asynchronous input
  // Bit 1 is the first sample considered stable
  // Bit 2 holds the previous stable sample for the edge compare
  logic [2:0] sync;

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      // Clearing the chain keeps a high input from looking like an edge
      sync <= '0;
    end else begin
      sync <= {sync[1:0], square_signal};
    end
  end

  // ******************************
  // Edge strobe
  // ******************************

  // Low in the older sample and high in the newer one marks a rising edge
  // The compare is registered so the strobe follows the sampling edge by two cycles
  always_ff @(posedge ref_clk) begin
    if (reset) begin
      edge_strobe <= 1'b0;
    end else begin
      edge_strobe <= sync[1] & ~sync[2];
    end
  end

endmodule

// File: flist.f
fmeter_pkg.sv
period_if.sv
edge_sync.sv
period_counter.sv
period_average.sv
fmeter_top.sv
tb_clock_gen.sv
tb_fmeter.sv

// File: fmeter_pkg.sv
// ******************************
// Shared constants of the frequency meter core
// Measurement widths, the timeout limit and the averaging depth
// ******************************

package fmeter_pkg;

  // ******************************
  // Period measurement
  // ******************************

  // Width of one period count in ref_clk cycles
  localparam int period_w = 16;

  // Largest count the period counter can hold
  // Reaching it without an edge means the input has stopped toggling
  localparam logic [period_w-1:0] max_period = '1;

  // ******************************
  // Averaging
  // ******************************

  // The average is taken over a power of two number of periods
  // so that the division becomes a plain right shift
  localparam int avg_log2 = 2;

  // Number of good periods in one averaging group
  localparam int avg_count = 1 << avg_log2;

  // The accumulator holds avg_count full scale periods without overflow
  localparam int sum_w = period_w + avg_log2;

endpackage

// File: fmeter_top.sv
// ******************************
// Frequency meter core top level
// ******************************

`timescale 1ns/1ps

module fmeter_top (
  input  logic                            ref_clk,
  input  logic                            reset,
  input  logic                            square_signal,
  output logic [fmeter_pkg::period_w-1:0] signal_period,
  output logic                            period_valid,
  output logic [fmeter_pkg::period_w-1:0] avg_period,
  output logic                            avg_valid,
  output logic                            signal_lost
);

  // Synchronized rising edge of the input
  logic edge_strobe;

  // Measurements from the counter to the averager
  period_if meas ();

  // Stage 1 synchronizes the input and finds its rising edges
  edge_sync u_edge_sync (
    .ref_clk       (ref_clk),
    .reset         (reset),
    .square_signal (square_signal),
    .edge_strobe   (edge_strobe)
  );

  // Stage 2 measures the time between edges
  period_counter u_period_counter (
    .ref_clk     (ref_clk),
    .reset       (reset),
    .edge_strobe (edge_strobe),
    .meas        (meas.source)
  );

  // Stage 3 publishes good periods and their averages
  period_average u_period_average (
    .ref_clk       (ref_clk),
    .reset         (reset),
    .meas          (meas.sink),
    .signal_period (signal_period),
    .period_valid  (period_valid),
    .avg_period    (avg_period),
    .avg_valid     (avg_valid)
  );

  // The loss level comes straight from the counter register
  assign signal_lost = meas.lost;

endmodule

// File: period_average.sv
// ******************************
// Period forwarding and group averaging
// Averages are never taken across a loss of signal
// ******************************

`timescale 1ns/1ps

module period_average (
  input  logic                            ref_clk,
  input  logic                            reset,
  period_if.sink                          meas,
  output logic [fmeter_pkg::period_w-1:0] signal_period,
  output logic                            period_valid,
  output logic [fmeter_pkg::period_w-1:0] avg_period,
  output logic                            avg_valid
);

  // Running sum of the good periods of the current group
  logic [fmeter_pkg::sum_w-1:0] sum;

  // Number of periods already in the current group
  logic [fmeter_pkg::avg_log2-1:0] group_cnt;

  // Sum including the period arriving in this cycle
  logic [fmeter_pkg::sum_w-1:0] next_sum;

  // A good period on the interface
  logic good;

  // The arriving period is the last one of its group
  logic group_done;

  // ******************************
  // Group bookkeeping
  // ******************************

  assign good = meas.strobe & ~meas.saturated;

  // Zero extend the period to the accumulator width
  assign next_sum = sum + {{fmeter_pkg::avg_log2{1'b0}}, meas.period};

  assign group_done =
    group_cnt == (fmeter_pkg::avg_log2)'(fmeter_pkg::avg_count - 1);

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      sum       <= '0;
      group_cnt <= '0;
    end else if (meas.strobe) begin
      if (meas.saturated || group_done) begin
        // A timeout drops the partial group
        // A full group has been published and the next one starts empty
        sum       <= '0;
        group_cnt <= '0;
      end else begin
        sum       <= next_sum;
        group_cnt <= group_cnt + 1'b1;
      end
    end
  end

  // ******************************
  // Result registers
  // ******************************

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      signal_period <= '0;
      period_valid  <= 1'b0;
      avg_period    <= '0;
      avg_valid     <= 1'b0;
    end else begin
      period_valid <= good;
      avg_valid    <= good & group_done;

      // Values hold between pulses
      if (good) begin
        signal_period <= meas.period;
      end

      // Dropping the low bits divides by avg_count with truncation
      if (good && group_done) begin
        avg_period <= next_sum[fmeter_pkg::sum_w-1:fmeter_pkg::avg_log2];
      end
    end
  end

endmodule

// File: period_counter.sv
// ******************************
// Period counter with saturation
// Counts ref_clk cycles between edges and flags signal loss
// ******************************

`timescale 1ns/1ps

module period_counter (
  input  logic     ref_clk,
  input  logic     reset,
  input  logic     edge_strobe,
  period_if.source meas
);

  // Cycles elapsed since the last accepted edge
  logic [fmeter_pkg::period_w-1:0] count;

  // Set once an edge has started a count
  // Without it there is no previous edge to measure from
  logic armed;

  // An edge that closes a running measurement
  logic edge_meas;

  // The count ran out before the next edge arrived
  logic timeout;

  // ******************************
  // Measurement events
  // ******************************

  assign edge_meas = edge_strobe & armed;

  // An edge in the same cycle still counts as a normal period of max_period
  assign timeout = armed & ~edge_strobe & (count == fmeter_pkg::max_period);

  // ******************************
  // Control state
  // ******************************

  always_ff @(posedge ref_clk) begin
    if (reset) begin
      count       <= '0;
      armed       <= 1'b0;
      meas.strobe <= 1'b0;
      meas.lost   <= 1'b0;
    end else begin
      // The strobe is a single cycle pulse unless an event renews it
      meas.strobe <= edge_meas | timeout;

      if (edge_strobe) begin
        // Every edge starts a new count, armed or not
        // The edge cycle itself is the first cycle of the new period
        count     <= {{(fmeter_pkg::period_w-1){1'b0}}, 1'b1};
        armed     <= 1'b1;
        meas.lost <= 1'b0;
      end else if (timeout) begin
        // Stop and wait for an edge to restart from scratch
        armed     <= 1'b0;
        meas.lost <= 1'b1;
      end else if (armed) begin
        count <= count + 1'b1;
      end
    end
  end

  // ******************************
  // Measurement payload
  // ******************************

  // Only loaded together with a strobe so the sink always sees a settled value
  always_ff @(posedge ref_clk) begin
    if (edge_meas) begin
      meas.period    <= count;
      meas.saturated <= 1'b0;
    end else if (timeout) begin
      meas.period    <= fmeter_pkg::max_period;
      meas.saturated <= 1'b1;
    end
  end

endmodule

// File: period_if.sv
// ******************************
// Period measurement interface
// Carries one measurement from the counter to the averager
// ******************************

`timescale 1ns/1ps

interface period_if;

  // High for a single cycle when a measurement is complete
  logic                            strobe;

  // Measured count in ref_clk cycles, valid with strobe
  logic [fmeter_pkg::period_w-1:0] period;

  // Set when the strobe comes from a timeout and not from an edge
  logic                            saturated;

  // Level flag, high from a timeout until the next input edge
  logic                            lost;

  // The counter produces measurements
  modport source (output strobe, output period, output saturated, output lost);

  // The averager consumes them
  modport sink (input strobe, input period, input saturated, input lost);

endinterface

// File: tb_clock_gen.sv
// ******************************
// Testbench clock and power on reset
// ******************************

`timescale 1ns/1ps

module tb_clock_gen (
  output logic ref_clk,
  output logic reset
);

  // 20 ns period, 50 MHz reference
  initial begin
    ref_clk = 1'b0;
    forever #10 ref_clk = ~ref_clk;
  end

  // Reset covers the first two rising edges and drops on the second one
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge ref_clk);
    reset <= 1'b0;
  end

endmodule

// File: tb_fmeter.sv
// ******************************
// Frequency meter testbench
// Random square wave, reference model of periods and averages, result monitor
// ******************************

`timescale 1ns/1ps

module tb_fmeter;

  // ******************************
  // DUT connections
  // ******************************

  logic                            ref_clk;
  logic                            por_reset;
  logic                            reset_req;
  logic                            reset;
  logic                            square_signal;
  logic [fmeter_pkg::period_w-1:0] signal_period;
  logic                            period_valid;
  logic [fmeter_pkg::period_w-1:0] avg_period;
  logic                            avg_valid;
  logic                            signal_lost;

  // Power on reset comes from the clock generator, the mid run reset from the stimulus
  assign reset = por_reset | reset_req;

  tb_clock_gen u_clock_gen (
    .ref_clk (ref_clk),
    .reset   (por_reset)
  );

  fmeter_top u_dut (
    .ref_clk       (ref_clk),
    .reset         (reset),
    .square_signal (square_signal),
    .signal_period (signal_period),
    .period_valid  (period_valid),
    .avg_period    (avg_period),
    .avg_valid     (avg_valid),
    .signal_lost   (signal_lost)
  );

  // ******************************
  // Reference model state
  // ******************************

  // Periods in the order the DUT has to report them
  int expect_q[$];

  // Rising clock edges since the last rising edge driven on the input
  int since_rise;

  // Set once a rising edge exists to measure from
  bit armed;

  // Group of good periods that the next average is built from
  int grp_sum;
  int grp_n;

  // Error and coverage counters for the closing line
  int errors;
  int periods_seen;
  int avgs_seen;

  // Phase of the run, shown in every error line
  string test_name;

  // ******************************
  // Helpers
  // ******************************

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail [%s] %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("Error [%s] %s", test_name, msg);
    errors++;
  endtask

  // Every stimulus cycle goes through here so the model sees each clock
  task automatic next_cycle();
    @(posedge ref_clk);
    since_rise++;
  endtask

  // A rising edge closes the input cycle that started at the previous one
  task automatic note_rise();
    if (armed && since_rise <= int'(fmeter_pkg::max_period)) begin
      expect_q.push_back(since_rise);
    end else if (armed) begin
      // The stalled period timed out in the counter, which drops the partial group
      grp_sum = 0;
      grp_n   = 0;
    end
    // Either way this edge only starts the next count
    armed      = 1'b1;
    since_rise = 0;
  endtask

  // Holds the input at one level for a number of sampling edges
  task automatic drive_level(input logic level, input int cycles);
    int i;
    if (level && !square_signal) begin
      note_rise();
    end
    square_signal <= level;
    for (i = 0; i < cycles; i++) begin
      next_cycle();
    end
  endtask

  // Whole input cycles with random high and low times of 1 to 40 cycles
  task automatic drive_random_periods(input int count);
    int i;
    int high_len;
    int low_len;
    for (i = 0; i < count; i++) begin
      high_len = 1 + ($urandom % 40);
      low_len  = 1 + ($urandom % 40);
      drive_level(1'b1, high_len);
      drive_level(1'b0, low_len);
    end
  endtask

  // Lets the pipeline report every period the model still holds
  task automatic wait_queue_empty(input int limit);
    int i;
    for (i = 0; i < limit && expect_q.size() != 0; i++) begin
      next_cycle();
    end
    if (expect_q.size() != 0) begin
      flag_error($sformatf("%0d expected periods were never reported", expect_q.size()));
    end
  endtask

  // Loss has to clear once an edge reaches the counter again
  task automatic wait_lost_clear(input int limit);
    int i;
    bit cleared;
    cleared = 1'b0;
    for (i = 0; i < limit && !cleared; i++) begin
      @(negedge ref_clk);
      cleared = !signal_lost;
      next_cycle();
    end
    if (!cleared) begin
      flag_error("signal_lost stayed high after the input started toggling again");
    end
  endtask

  // All result outputs at their reset values, sampled mid cycle
  task automatic check_idle_outputs();
    @(negedge ref_clk);
    check_value("signal_period at reset", 0, signal_period);
    check_value("period_valid at reset", 0, period_valid);
    check_value("avg_period at reset", 0, avg_period);
    check_value("avg_valid at reset", 0, avg_valid);
    check_value("signal_lost at reset", 0, signal_lost);
    next_cycle();
  endtask

  // Two cycle reset in the middle of activity
  task automatic apply_mid_reset();
    reset_req     <= 1'b1;
    square_signal <= 1'b0;
    // The model starts over together with the DUT
    expect_q.delete();
    grp_sum    = 0;
    grp_n      = 0;
    armed      = 1'b0;
    since_rise = 0;
    next_cycle();
    next_cycle();
    check_idle_outputs();
    reset_req <= 1'b0;
  endtask

  // ******************************
  // Result monitor
  // ******************************

  // Outputs are registered on the rising edge, so the falling edge sees them settled
  always @(negedge ref_clk) begin : result_monitor
    int exp_period;
    if (reset === 1'b0) begin
      if (period_valid) begin
        if (expect_q.size() == 0) begin
          flag_error("period_valid pulsed while no period was expected");
        end else begin
          exp_period = expect_q.pop_front();
          check_value("signal_period", exp_period, signal_period);
          check_value("signal_lost with a period", 0, signal_lost);
          periods_seen++;
          grp_sum += exp_period;
          grp_n++;
          // Every fourth good period also closes a group
          if (grp_n == fmeter_pkg::avg_count) begin
            check_value("avg_valid", 1, avg_valid);
            check_value("avg_period", grp_sum / fmeter_pkg::avg_count, avg_period);
            avgs_seen++;
            grp_sum = 0;
            grp_n   = 0;
          end else begin
            check_value("avg_valid", 0, avg_valid);
          end
        end
      end else if (avg_valid) begin
        flag_error("avg_valid pulsed without period_valid");
      end
    end
  end

  // ******************************
  // Stimulus sequence
  // ******************************

  initial begin
    int i;
    square_signal = 1'b0;
    reset_req     = 1'b0;
    since_rise    = 0;
    armed         = 1'b0;
    grp_sum       = 0;
    grp_n         = 0;
    errors        = 0;
    periods_seen  = 0;
    avgs_seen     = 0;
    void'($urandom(32'hdf71));

    test_name = "power on reset";
    @(posedge ref_clk);
    for (i = 0; i < 20 && reset !== 1'b0; i++) begin
      @(posedge ref_clk);
    end
    if (reset !== 1'b0) begin
      flag_error("power on reset was never released");
    end
    check_idle_outputs();

    // The first rising edge only arms the counter
    test_name = "steady periods";
    drive_random_periods(200);
    wait_queue_empty(400);

    // Two more periods leave a half filled group for the stall to discard
    test_name = "signal loss";
    drive_random_periods(2);

    // A stall far past max_period, then the input resumes
    drive_level(1'b1, 70000);
    @(negedge ref_clk);
    check_value("signal_lost during stall", 1, signal_lost);
    next_cycle();
    drive_level(1'b0, 5);
    drive_level(1'b1, 1);
    wait_lost_clear(20);
    drive_level(1'b0, 3);
    drive_random_periods(40);
    wait_queue_empty(400);

    // One cycle high and one low, a measurement every other cycle
    test_name = "minimum period";
    for (i = 0; i < 64; i++) begin
      drive_level(1'b1, 1);
      drive_level(1'b0, 1);
    end
    wait_queue_empty(100);

    // Reset lands in the middle of a high phase
    test_name = "reset mid run";
    drive_random_periods(30);
    drive_level(1'b1, 7);
    apply_mid_reset();
    drive_random_periods(200);
    wait_queue_empty(400);

    $display("Errors: %0d, periods checked: %0d, averages checked: %0d",
             errors, periods_seen, avgs_seen);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
